// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // Source of the first ALU operand
    typedef enum logic [1:0] {
        op1_rs1,
        op1_pc,
        op1_imz,
        op1_zero
    } op1_sel_t;

    // Source of the second ALU operand
    typedef enum logic [2:0] {
        op2_rs2,
        op2_imi,
        op2_ims,
        op2_imj,
        op2_imu,
        op2_zero
    } op2_sel_t;

    // One instruction word seen through the base RV32I formats
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [6:0]            imm_hi;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;
            logic [6:0]            opcode;
        } s;
        // B and J formats reuse these views with scrambled immediate bits
        struct packed {
            logic [19:0]           imm20;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } inst_t;

    // Major opcodes
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_system = 7'b1110011;

endpackage

// ==== hw/inst_decoder.sv ====
module inst_decoder (
    input  rv_pkg::inst_t              inst,
    output rv_pkg::op1_sel_t           op1_sel,
    output rv_pkg::op2_sel_t           op2_sel,
    output logic [rv_pkg::xlen-1:0]    imm_i,
    output logic [rv_pkg::xlen-1:0]    imm_s,
    output logic [rv_pkg::xlen-1:0]    imm_j,
    output logic [rv_pkg::xlen-1:0]    imm_u,
    output logic [rv_pkg::xlen-1:0]    imm_z
);

    import rv_pkg::*;

    assign imm_i = {{(xlen-12){inst.i.imm[11]}}, inst.i.imm};

    assign imm_s = {{(xlen-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};

    // J immediate is imm[20|10:1|11|19:12] packed into the upper 20 bits
    assign imm_j = {{(xlen-21){inst.u.imm20[19]}},
                    inst.u.imm20[19],
                    inst.u.imm20[7:0],
                    inst.u.imm20[8],
                    inst.u.imm20[18:9],
                    1'b0};

    assign imm_u = {inst.u.imm20, 12'b0};

    // CSR immediate forms carry uimm in the rs1 field
    assign imm_z = {{(xlen-reg_addr_w){1'b0}}, inst.i.rs1};

    always_comb begin
        op1_sel = op1_zero;
        op2_sel = op2_zero;
        case (inst.r.opcode)
            opc_op: begin
                op1_sel = op1_rs1;
                op2_sel = op2_rs2;
            end
            opc_op_imm, opc_load, opc_jalr: begin
                op1_sel = op1_rs1;
                op2_sel = op2_imi;
            end
            opc_store: begin
                op1_sel = op1_rs1;
                op2_sel = op2_ims;
            end
            opc_lui: begin
                op1_sel = op1_zero;
                op2_sel = op2_imu;
            end
            opc_auipc: begin
                op1_sel = op1_pc;
                op2_sel = op2_imu;
            end
            opc_jal: begin
                op1_sel = op1_pc;
                op2_sel = op2_imj;
            end
            opc_branch: begin
                op1_sel = op1_rs1;
                op2_sel = op2_rs2;
            end
            opc_system: begin
                // csrrwi / csrrsi / csrrci
                if (inst.r.funct3[2]) begin
                    op1_sel = op1_imz;
                    op2_sel = op2_zero;
                end
            end
            default: begin
                op1_sel = op1_zero;
                op2_sel = op2_zero;
            end
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             we,
    input  logic [rv_pkg::reg_addr_w-1:0]    waddr,
    input  logic [rv_pkg::xlen-1:0]          wdata,
    input  logic [rv_pkg::reg_addr_w-1:0]    raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0]    raddr2,
    output logic [rv_pkg::xlen-1:0]          rdata1,
    output logic [rv_pkg::xlen-1:0]          rdata2
);

    import rv_pkg::*;

    localparam int depth = 1 << reg_addr_w;

    logic [xlen-1:0] regs [depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero regardless of array contents
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hw/operand_select.sv ====
module operand_select (
    input  rv_pkg::inst_t                    inst,
    input  logic [rv_pkg::xlen-1:0]          pc,
    input  logic                             valid,
    input  rv_pkg::op1_sel_t                 op1_sel,
    input  rv_pkg::op2_sel_t                 op2_sel,
    input  logic [rv_pkg::xlen-1:0]          imm_i,
    input  logic [rv_pkg::xlen-1:0]          imm_s,
    input  logic [rv_pkg::xlen-1:0]          imm_j,
    input  logic [rv_pkg::xlen-1:0]          imm_u,
    input  logic [rv_pkg::xlen-1:0]          imm_z,

    output logic [rv_pkg::reg_addr_w-1:0]    rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0]    rs2_addr,
    input  logic [rv_pkg::xlen-1:0]          rs1_rdata,
    input  logic [rv_pkg::xlen-1:0]          rs2_rdata,

    input  logic                             fw_exe_valid,
    input  logic [rv_pkg::reg_addr_w-1:0]    fw_exe_addr,
    input  logic [rv_pkg::xlen-1:0]          fw_exe_wdata,
    input  logic                             fw_exe_fwdable,
    input  logic                             fw_mem_valid,
    input  logic [rv_pkg::reg_addr_w-1:0]    fw_mem_addr,
    input  logic [rv_pkg::xlen-1:0]          fw_mem_wdata,
    input  logic                             fw_mem_fwdable,
    input  logic                             fw_csr_valid,
    input  logic [rv_pkg::reg_addr_w-1:0]    fw_csr_addr,
    input  logic [rv_pkg::xlen-1:0]          fw_csr_wdata,
    input  logic                             fw_csr_fwdable,
    input  logic                             fw_wbk_valid,
    input  logic [rv_pkg::reg_addr_w-1:0]    fw_wbk_addr,
    input  logic [rv_pkg::xlen-1:0]          fw_wbk_wdata,
    input  logic                             fw_wbk_fwdable,

    output logic [rv_pkg::xlen-1:0]          next_op1,
    output logic [rv_pkg::xlen-1:0]          next_op2,
    output logic [rv_pkg::xlen-1:0]          next_rs2,
    output logic                             hazard
);

    import rv_pkg::*;

    // Index 0 has the highest priority
    logic [3:0]                       fw_valid;
    logic [3:0][reg_addr_w-1:0]       fw_addr;
    logic [3:0][xlen-1:0]             fw_wdata;
    logic [3:0]                       fw_fwdable;

    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            rs1_blocked;
    logic            rs2_blocked;

    assign fw_valid   = {fw_wbk_valid, fw_csr_valid, fw_mem_valid, fw_exe_valid};
    assign fw_addr    = {fw_wbk_addr, fw_csr_addr, fw_mem_addr, fw_exe_addr};
    assign fw_wdata   = {fw_wbk_wdata, fw_csr_wdata, fw_mem_wdata, fw_exe_wdata};
    assign fw_fwdable = {fw_wbk_fwdable, fw_csr_fwdable, fw_mem_fwdable, fw_exe_fwdable};

    function automatic void resolve(
        input  logic [reg_addr_w-1:0]       rs,
        input  logic [xlen-1:0]             rf_data,
        input  logic [3:0]                  f_valid,
        input  logic [3:0][reg_addr_w-1:0]  f_addr,
        input  logic [3:0][xlen-1:0]        f_wdata,
        input  logic [3:0]                  f_fwdable,
        output logic [xlen-1:0]             data,
        output logic                        blocked
    );
        logic found;
        found   = 1'b0;
        data    = rf_data;
        blocked = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (!found && f_valid[i] && f_addr[i] == rs && rs != '0) begin
                found   = 1'b1;
                data    = f_wdata[i];
                blocked = !f_fwdable[i];
            end
        end
    endfunction

    assign rs1_addr = inst.r.rs1;
    assign rs2_addr = inst.r.rs2;

    always_comb begin
        resolve(rs1_addr, rs1_rdata, fw_valid, fw_addr, fw_wdata, fw_fwdable,
                rs1_data, rs1_blocked);
        resolve(rs2_addr, rs2_rdata, fw_valid, fw_addr, fw_wdata, fw_fwdable,
                rs2_data, rs2_blocked);
    end

    // Both fields are checked even when the opcode ignores one of them
    assign hazard = valid && (rs1_blocked || rs2_blocked);

    always_comb begin
        case (op1_sel)
            op1_rs1: next_op1 = rs1_data;
            op1_pc:  next_op1 = pc;
            op1_imz: next_op1 = imm_z;
            default: next_op1 = '0;
        endcase
    end

    always_comb begin
        case (op2_sel)
            op2_rs2: next_op2 = rs2_data;
            op2_imi: next_op2 = imm_i;
            op2_ims: next_op2 = imm_s;
            op2_imj: next_op2 = imm_j;
            op2_imu: next_op2 = imm_u;
            default: next_op2 = '0;
        endcase
    end

    // Store data and branch compare source
    assign next_rs2 = rs2_data;

endmodule

// ==== hw/operand_latch.sv ====
module operand_latch (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic                       stall,
    input  logic [rv_pkg::xlen-1:0]    op1,
    input  logic [rv_pkg::xlen-1:0]    op2,
    input  logic [rv_pkg::xlen-1:0]    rs2,
    output logic                       out_valid,
    output logic [rv_pkg::xlen-1:0]    out_op1,
    output logic [rv_pkg::xlen-1:0]    out_op2,
    output logic [rv_pkg::xlen-1:0]    out_rs2
);

    logic load;

    // A stalled instruction turns into a bubble
    assign load = in_valid && !stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= load;
        end
    end

    // Operands stay put across bubbles
    always_ff @(posedge clk) begin
        if (load) begin
            out_op1 <= op1;
            out_op2 <= op2;
            out_rs2 <= rs2;
        end
    end

endmodule

// ==== hw/operand_stage_top.sv ====
module operand_stage_top (
    input  logic                             clk,
    input  logic                             rst_n,

    input  logic                             inst_valid,
    input  rv_pkg::inst_t                    inst,
    input  logic [rv_pkg::xlen-1:0]          pc,

    input  logic                             wb_en,
    input  logic [rv_pkg::reg_addr_w-1:0]    wb_addr,
    input  logic [rv_pkg::xlen-1:0]          wb_data,

    input  logic                             fw_exe_valid,
    input  logic [rv_pkg::reg_addr_w-1:0]    fw_exe_addr,
    input  logic [rv_pkg::xlen-1:0]          fw_exe_wdata,
    input  logic                             fw_exe_fwdable,
    input  logic                             fw_mem_valid,
    input  logic [rv_pkg::reg_addr_w-1:0]    fw_mem_addr,
    input  logic [rv_pkg::xlen-1:0]          fw_mem_wdata,
    input  logic                             fw_mem_fwdable,
    input  logic                             fw_csr_valid,
    input  logic [rv_pkg::reg_addr_w-1:0]    fw_csr_addr,
    input  logic [rv_pkg::xlen-1:0]          fw_csr_wdata,
    input  logic                             fw_csr_fwdable,
    input  logic                             fw_wbk_valid,
    input  logic [rv_pkg::reg_addr_w-1:0]    fw_wbk_addr,
    input  logic [rv_pkg::xlen-1:0]          fw_wbk_wdata,
    input  logic                             fw_wbk_fwdable,

    output logic                             stall,
    output logic                             out_valid,
    output logic [rv_pkg::xlen-1:0]          out_op1,
    output logic [rv_pkg::xlen-1:0]          out_op2,
    output logic [rv_pkg::xlen-1:0]          out_rs2
);

    import rv_pkg::*;

    op1_sel_t              op1_sel;
    op2_sel_t              op2_sel;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_s;
    logic [xlen-1:0]       imm_j;
    logic [xlen-1:0]       imm_u;
    logic [xlen-1:0]       imm_z;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_rdata;
    logic [xlen-1:0]       rs2_rdata;
    logic [xlen-1:0]       next_op1;
    logic [xlen-1:0]       next_op2;
    logic [xlen-1:0]       next_rs2;

    inst_decoder u_decoder (
        .inst    (inst),
        .op1_sel (op1_sel),
        .op2_sel (op2_sel),
        .imm_i   (imm_i),
        .imm_s   (imm_s),
        .imm_j   (imm_j),
        .imm_u   (imm_u),
        .imm_z   (imm_z)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_rdata),
        .rdata2 (rs2_rdata)
    );

    operand_select u_select (
        .inst           (inst),
        .pc             (pc),
        .valid          (inst_valid),
        .op1_sel        (op1_sel),
        .op2_sel        (op2_sel),
        .imm_i          (imm_i),
        .imm_s          (imm_s),
        .imm_j          (imm_j),
        .imm_u          (imm_u),
        .imm_z          (imm_z),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_rdata      (rs1_rdata),
        .rs2_rdata      (rs2_rdata),
        .fw_exe_valid   (fw_exe_valid),
        .fw_exe_addr    (fw_exe_addr),
        .fw_exe_wdata   (fw_exe_wdata),
        .fw_exe_fwdable (fw_exe_fwdable),
        .fw_mem_valid   (fw_mem_valid),
        .fw_mem_addr    (fw_mem_addr),
        .fw_mem_wdata   (fw_mem_wdata),
        .fw_mem_fwdable (fw_mem_fwdable),
        .fw_csr_valid   (fw_csr_valid),
        .fw_csr_addr    (fw_csr_addr),
        .fw_csr_wdata   (fw_csr_wdata),
        .fw_csr_fwdable (fw_csr_fwdable),
        .fw_wbk_valid   (fw_wbk_valid),
        .fw_wbk_addr    (fw_wbk_addr),
        .fw_wbk_wdata   (fw_wbk_wdata),
        .fw_wbk_fwdable (fw_wbk_fwdable),
        .next_op1       (next_op1),
        .next_op2       (next_op2),
        .next_rs2       (next_rs2),
        .hazard         (stall)
    );

    operand_latch u_latch (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (inst_valid),
        .stall     (stall),
        .op1       (next_op1),
        .op2       (next_op2),
        .rs2       (next_rs2),
        .out_valid (out_valid),
        .out_op1   (out_op1),
        .out_op2   (out_op2),
        .out_rs2   (out_rs2)
    );

endmodule

// ==== tests/clock_gen.sv ====
module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held low for 8 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== tests/operand_stage_tb.sv ====
module operand_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        fw_exe_valid, fw_mem_valid, fw_csr_valid, fw_wbk_valid;
    logic [4:0]  fw_exe_addr, fw_mem_addr, fw_csr_addr, fw_wbk_addr;
    logic [31:0] fw_exe_wdata, fw_mem_wdata, fw_csr_wdata, fw_wbk_wdata;
    logic        fw_exe_fwdable, fw_mem_fwdable, fw_csr_fwdable, fw_wbk_fwdable;
    logic        stall;
    logic        out_valid;
    logic [31:0] out_op1, out_op2, out_rs2;

    // Register mirror and what the latch should show after the next edge
    logic [31:0] mirror [32] = '{default: '0};
    logic        exp_valid;
    logic [31:0] exp_op1, exp_op2, exp_rs2;
    logic        data_known;
    logic [15:0] lfsr = 16'd60;
    string       test_name;

    // fence stands in for an opcode that selects nothing
    logic [6:0] opcodes [11] = '{opc_op, opc_op_imm, opc_load, opc_store, opc_lui,
        opc_auipc, opc_jal, opc_jalr, opc_branch, opc_system, 7'b0001111};

    clock_gen u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    operand_stage_top uut (.*);

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, name, expected, actual);
            $display("tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timed out waiting for %s in test %s", what, test_name);
        $display("tests failed");
        $fatal(1, "timeout");
    endtask

    // Priority exe, mem, csr, wbk, then the mirror
    function automatic void forward_source(input logic [4:0] rs, output logic [31:0] val,
                                           output logic blocked);
        val = mirror[rs];
        blocked = 1'b0;
        if (rs == 5'd0) begin
            val = '0;
        end else if (fw_exe_valid && fw_exe_addr == rs) begin
            val = fw_exe_wdata;
            blocked = !fw_exe_fwdable;
        end else if (fw_mem_valid && fw_mem_addr == rs) begin
            val = fw_mem_wdata;
            blocked = !fw_mem_fwdable;
        end else if (fw_csr_valid && fw_csr_addr == rs) begin
            val = fw_csr_wdata;
            blocked = !fw_csr_fwdable;
        end else if (fw_wbk_valid && fw_wbk_addr == rs) begin
            val = fw_wbk_wdata;
            blocked = !fw_wbk_fwdable;
        end
    endfunction

    task automatic clear_inputs();
        inst_valid <= 1'b0;
        inst <= '0;
        pc <= '0;
        wb_en <= 1'b0;
        wb_addr <= '0;
        wb_data <= '0;
        fw_exe_valid <= 1'b0;
        fw_mem_valid <= 1'b0;
        fw_csr_valid <= 1'b0;
        fw_wbk_valid <= 1'b0;
        fw_exe_fwdable <= 1'b0;
        fw_mem_fwdable <= 1'b0;
        fw_csr_fwdable <= 1'b0;
        fw_wbk_fwdable <= 1'b0;
    endtask

    // Checks at the falling edge, then predicts the next edge
    task automatic advance_and_check();
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] op1;
        logic [31:0] op2;
        logic        b1;
        logic        b2;
        logic        exp_stall;
        @(negedge clk);
        check_value("out_valid", exp_valid, out_valid);
        if (data_known) begin
            check_value("out_op1", exp_op1, out_op1);
            check_value("out_op2", exp_op2, out_op2);
            check_value("out_rs2", exp_rs2, out_rs2);
        end
        forward_source(inst[19:15], rs1_v, b1);
        forward_source(inst[24:20], rs2_v, b2);
        exp_stall = inst_valid && (b1 || b2);
        check_value("stall", exp_stall, stall);
        case (inst[6:0])
            opc_op, opc_op_imm, opc_load, opc_store, opc_jalr, opc_branch: op1 = rs1_v;
            opc_auipc, opc_jal: op1 = pc;
            opc_system: op1 = inst[14] ? {27'd0, inst[19:15]} : '0;
            default: op1 = '0;
        endcase
        case (inst[6:0])
            opc_op, opc_branch: op2 = rs2_v;
            opc_op_imm, opc_load, opc_jalr: op2 = {{20{inst[31]}}, inst[31:20]};
            opc_store: op2 = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            opc_lui, opc_auipc: op2 = {inst[31:12], 12'h000};
            opc_jal: op2 = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: op2 = '0;
        endcase
        exp_valid = inst_valid && !exp_stall;
        if (exp_valid) begin
            exp_op1 = op1;
            exp_op2 = op2;
            exp_rs2 = rs2_v;
            data_known = 1'b1;
        end
        if (wb_en && wb_addr != 5'd0) begin
            mirror[wb_addr] = wb_data;
        end
    endtask

    // Narrow mode keeps rs fields and addresses in x0..x3 so sources collide often
    task automatic drive_random_cycle(input bit fwd, input bit narrow);
        logic [31:0] word;
        logic [4:0]  amask;
        int          idx;
        idx = int'(rand_bits(4) % 11);
        word = {25'(rand_bits(25)), opcodes[idx]};
        amask = narrow ? 5'd3 : 5'd31;
        if (narrow) begin
            word[19:15] = 5'(rand_bits(2));
            word[24:20] = 5'(rand_bits(2));
        end
        @(posedge clk);
        inst_valid <= rand_bits(3) != 0;
        inst <= word;
        pc <= {30'(rand_bits(30)), 2'b00};
        wb_en <= 1'(rand_bits(1));
        wb_addr <= 5'(rand_bits(5)) & amask;
        wb_data <= rand_bits(32);
        fw_exe_valid <= fwd && rand_bits(1);
        fw_mem_valid <= fwd && rand_bits(1);
        fw_csr_valid <= fwd && rand_bits(1);
        fw_wbk_valid <= fwd && rand_bits(1);
        fw_exe_addr <= 5'(rand_bits(2));
        fw_mem_addr <= 5'(rand_bits(2));
        fw_csr_addr <= 5'(rand_bits(2));
        fw_wbk_addr <= 5'(rand_bits(2));
        fw_exe_wdata <= rand_bits(32);
        fw_mem_wdata <= rand_bits(32);
        fw_csr_wdata <= rand_bits(32);
        fw_wbk_wdata <= rand_bits(32);
        fw_exe_fwdable <= 1'b1;
        fw_mem_fwdable <= 1'b1;
        fw_csr_fwdable <= 1'b1;
        fw_wbk_fwdable <= 1'b1;
        advance_and_check();
    endtask

    initial begin
        int          n;
        logic [31:0] word;
        logic [4:0]  r;
        logic [31:0] v;
        clear_inputs();
        fw_exe_addr <= '0;
        fw_mem_addr <= '0;
        fw_csr_addr <= '0;
        fw_wbk_addr <= '0;
        fw_exe_wdata <= '0;
        fw_mem_wdata <= '0;
        fw_csr_wdata <= '0;
        fw_wbk_wdata <= '0;
        exp_valid = 1'b0;
        data_known = 1'b0;

        test_name = "reset";
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n == 50) abort_on_timeout("reset release");
            @(posedge clk);
            n++;
        end
        advance_and_check();
        for (int i = 0; i < 32; i++) begin
            r = 5'(i);
            word = {12'(rand_bits(12)), r, 3'b000, 5'd1, opc_op_imm};
            @(posedge clk);
            clear_inputs();
            inst_valid <= 1'b1;
            inst <= word;
            advance_and_check();
        end

        test_name = "operand select";
        repeat (200) drive_random_cycle(1'b0, 1'b0);

        // First pass writes x0
        test_name = "write-back";
        for (int k = 0; k < 16; k++) begin
            r = (k == 0) ? 5'd0 : 5'(rand_bits(5));
            v = rand_bits(32);
            @(posedge clk);
            clear_inputs();
            wb_en <= 1'b1;
            wb_addr <= r;
            wb_data <= v;
            advance_and_check();
            @(posedge clk);
            clear_inputs();
            inst_valid <= 1'b1;
            inst <= {7'd0, r, r, 3'b000, 5'd2, opc_op};
            advance_and_check();
        end

        test_name = "forwarding";
        repeat (300) drive_random_cycle(1'b1, 1'b1);

        test_name = "hazard";
        repeat (24) begin
            r = 5'(rand_bits(2)) + 5'd1;
            word = {7'd0, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'b000, 5'd4, opc_op};
            if (rand_bits(1) != 0) begin
                word[19:15] = r;
            end else begin
                word[24:20] = r;
            end
            @(posedge clk);
            clear_inputs();
            inst_valid <= 1'b1;
            inst <= word;
            fw_exe_wdata <= rand_bits(32);
            fw_mem_wdata <= rand_bits(32);
            fw_csr_wdata <= rand_bits(32);
            fw_wbk_wdata <= rand_bits(32);
            fw_exe_addr <= r;
            fw_mem_addr <= r;
            fw_csr_addr <= r;
            fw_wbk_addr <= r;
            case (rand_bits(2))
                0: fw_exe_valid <= 1'b1;
                1: fw_mem_valid <= 1'b1;
                2: fw_csr_valid <= 1'b1;
                default: fw_wbk_valid <= 1'b1;
            endcase
            advance_and_check();
            check_value("stall raised", 32'd1, {31'd0, stall});
            // Instruction held, bubble expected with data unchanged
            @(posedge clk);
            advance_and_check();
            @(posedge clk);
            fw_exe_fwdable <= 1'b1;
            fw_mem_fwdable <= 1'b1;
            fw_csr_fwdable <= 1'b1;
            fw_wbk_fwdable <= 1'b1;
            advance_and_check();
            n = 0;
            do begin
                if (n == 10) abort_on_timeout("out_valid after hazard release");
                @(posedge clk);
                clear_inputs();
                advance_and_check();
                n++;
            end while (!out_valid);
        end

        test_name = "drain";
        @(posedge clk);
        clear_inputs();
        advance_and_check();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/rv_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/operand_select.sv
hw/operand_latch.sv
hw/operand_stage_top.sv
tests/clock_gen.sv
tests/operand_stage_tb.sv

// ==== Bender.yml ====
package:
  name: operand_stage

sources:
  - hw/rv_pkg.sv
  - hw/inst_decoder.sv
  - hw/reg_file.sv
  - hw/operand_select.sv
  - hw/operand_latch.sv
  - hw/operand_stage_top.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/operand_stage_tb.sv
